/* Bender.yml */
package:
  name: axil_apb_bridge

sources:
  - apb_bridge_pkg.sv
  - axil_req_arbiter.sv
  - apb_master_fsm.sv
  - axil_resp_unit.sv
  - axil_apb_bridge.sv
  - target: test
    files:
      - tb_axil_apb_bridge.sv

/* apb_bridge_pkg.sv */
package apb_bridge_pkg;

    // AXI response code as it appears on bresp and rresp
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    localparam int PROT_WIDTH = 3; // same field width on AXI and APB

    localparam int DEFAULT_NO_APBS    = 8;
    localparam int DEFAULT_ADDR_WIDTH = 32;
    localparam int DEFAULT_DATA_WIDTH = 32;
    localparam int DEFAULT_SPAN_BITS  = 16; // each slave sees 64 KiB

endpackage

/* apb_master_fsm.sv */
`timescale 1ns/100ps

module apb_master_fsm #(
    parameter int NO_APBS         = apb_bridge_pkg::DEFAULT_NO_APBS,
    parameter int ADDR_WIDTH      = apb_bridge_pkg::DEFAULT_ADDR_WIDTH,
    parameter int DATA_WIDTH      = apb_bridge_pkg::DEFAULT_DATA_WIDTH,
    parameter int SLAVE_SPAN_BITS = apb_bridge_pkg::DEFAULT_SPAN_BITS
) (
    input  logic                                  seq,
    input  logic                                  rst,

    input  logic                                  req,
    input  logic                                  req_write,
    input  logic [ADDR_WIDTH-1:0]                 req_addr,
    input  logic [apb_bridge_pkg::PROT_WIDTH-1:0] req_prot,
    input  logic [DATA_WIDTH-1:0]                 req_wdata,
    input  logic [DATA_WIDTH/8-1:0]               req_strb,
    output logic                                  busy,

    output logic                                  psel    [NO_APBS],
    output logic                                  penable [NO_APBS],
    output logic [ADDR_WIDTH-1:0]                 paddr,
    output logic [apb_bridge_pkg::PROT_WIDTH-1:0] pprot,
    output logic                                  pwrite,
    output logic [DATA_WIDTH-1:0]                 pwdata,
    output logic [DATA_WIDTH/8-1:0]               pstrb,
    input  logic                                  pready  [NO_APBS],
    input  logic [DATA_WIDTH-1:0]                 prdata  [NO_APBS],
    input  logic                                  pslverr [NO_APBS],

    output logic                                  done,
    output logic                                  done_write,
    output apb_bridge_pkg::resp_t                 done_resp,
    output logic [DATA_WIDTH-1:0]                 done_rdata
);

    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int SEL_WIDTH  = (NO_APBS > 1) ? $clog2(NO_APBS) : 1;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_SETUP  = 2'd1;
    localparam logic [1:0] S_ACCESS = 2'd2;
    localparam logic [1:0] S_DECERR = 2'd3;

    logic [1:0]            state;
    logic [SEL_WIDTH-1:0]  sel;
    logic [ADDR_WIDTH-1:0] window;
    logic                  in_map;
    logic                  sel_ready;
    logic [DATA_WIDTH-1:0] sel_rdata;
    logic                  sel_err;
    logic [STRB_WIDTH-1:0] strb_q;

    assign window = req_addr >> SLAVE_SPAN_BITS; // slave index sits right above the window
    assign in_map = (window < NO_APBS);

    always_ff @(posedge seq) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req) begin
                        state <= in_map ? S_SETUP : S_DECERR;
                    end
                end
                S_SETUP: begin
                    state <= S_ACCESS;
                end
                S_ACCESS: begin
                    if (sel_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE; // DECERR lasts one cycle
                end
            endcase
        end
    end

    // the transfer fields stay put from SETUP until the next request
    always_ff @(posedge seq) begin
        if (state == S_IDLE && req) begin
            sel    <= window[SEL_WIDTH-1:0];
            paddr  <= req_addr;
            pprot  <= req_prot;
            pwrite <= req_write;
            pwdata <= req_wdata;
            strb_q <= req_strb;
        end
    end

    assign pstrb = strb_q;

    always_comb begin
        sel_ready = 1'b0;
        sel_rdata = '0;
        sel_err   = 1'b0;
        for (int i = 0; i < NO_APBS; i++) begin
            if (sel == SEL_WIDTH'(i)) begin
                sel_ready = pready[i];
                sel_rdata = prdata[i];
                sel_err   = pslverr[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NO_APBS; i++) begin
            psel[i]    = (state == S_SETUP || state == S_ACCESS) && (sel == SEL_WIDTH'(i));
            penable[i] = (state == S_ACCESS) && (sel == SEL_WIDTH'(i));
        end
    end

    assign busy = (state != S_IDLE);

    // the response unit registers this, so valid follows one cycle later
    assign done       = (state == S_ACCESS && sel_ready) || state == S_DECERR;
    assign done_write = pwrite;
    assign done_rdata = (state == S_DECERR) ? '0 : sel_rdata;

    always_comb begin
        if (state == S_DECERR) begin
            done_resp = apb_bridge_pkg::RESP_DECERR;
        end else if (sel_err) begin
            done_resp = apb_bridge_pkg::RESP_SLVERR;
        end else begin
            done_resp = apb_bridge_pkg::RESP_OKAY;
        end
    end

endmodule

/* axil_apb_bridge.sv */
`timescale 1ns/100ps

module axil_apb_bridge #(
    parameter int NO_APBS         = apb_bridge_pkg::DEFAULT_NO_APBS,
    parameter int ADDR_WIDTH      = apb_bridge_pkg::DEFAULT_ADDR_WIDTH,
    parameter int DATA_WIDTH      = apb_bridge_pkg::DEFAULT_DATA_WIDTH,
    parameter int SLAVE_SPAN_BITS = apb_bridge_pkg::DEFAULT_SPAN_BITS
) (
    input  logic                                  seq,
    input  logic                                  rst,

    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [ADDR_WIDTH-1:0]                 awaddr,
    input  logic [apb_bridge_pkg::PROT_WIDTH-1:0] awprot,
    input  logic                                  wvalid,
    output logic                                  wready,
    input  logic [DATA_WIDTH-1:0]                 wdata,
    input  logic [DATA_WIDTH/8-1:0]               wstrb,
    output logic                                  bvalid,
    input  logic                                  bready,
    output apb_bridge_pkg::resp_t                 bresp,
    input  logic                                  arvalid,
    output logic                                  arready,
    input  logic [ADDR_WIDTH-1:0]                 araddr,
    input  logic [apb_bridge_pkg::PROT_WIDTH-1:0] arprot,
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic [DATA_WIDTH-1:0]                 rdata,
    output apb_bridge_pkg::resp_t                 rresp,

    output logic                                  psel    [NO_APBS],
    output logic                                  penable [NO_APBS],
    output logic [ADDR_WIDTH-1:0]                 paddr,
    output logic [apb_bridge_pkg::PROT_WIDTH-1:0] pprot,
    output logic                                  pwrite,
    output logic [DATA_WIDTH-1:0]                 pwdata,
    output logic [DATA_WIDTH/8-1:0]               pstrb,
    input  logic                                  pready  [NO_APBS],
    input  logic [DATA_WIDTH-1:0]                 prdata  [NO_APBS],
    input  logic                                  pslverr [NO_APBS]
);

    logic                                  req;
    logic                                  req_write;
    logic [ADDR_WIDTH-1:0]                 req_addr;
    logic [apb_bridge_pkg::PROT_WIDTH-1:0] req_prot;
    logic [DATA_WIDTH-1:0]                 req_wdata;
    logic [DATA_WIDTH/8-1:0]               req_strb;
    logic                                  busy;
    logic                                  done;
    logic                                  done_write;
    apb_bridge_pkg::resp_t                 done_resp;
    logic [DATA_WIDTH-1:0]                 done_rdata;
    logic                                  b_full;
    logic                                  r_full;

    axil_req_arbiter #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_arbiter (
        .seq       (seq),
        .rst       (rst),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .awprot    (awprot),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .arprot    (arprot),
        .busy      (busy),
        .b_full    (b_full),
        .r_full    (r_full),
        .req       (req),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_prot  (req_prot),
        .req_wdata (req_wdata),
        .req_strb  (req_strb)
    );

    apb_master_fsm #(
        .NO_APBS         (NO_APBS),
        .ADDR_WIDTH      (ADDR_WIDTH),
        .DATA_WIDTH      (DATA_WIDTH),
        .SLAVE_SPAN_BITS (SLAVE_SPAN_BITS)
    ) u_fsm (
        .seq        (seq),
        .rst        (rst),
        .req        (req),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_prot   (req_prot),
        .req_wdata  (req_wdata),
        .req_strb   (req_strb),
        .busy       (busy),
        .psel       (psel),
        .penable    (penable),
        .paddr      (paddr),
        .pprot      (pprot),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .pready     (pready),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .done       (done),
        .done_write (done_write),
        .done_resp  (done_resp),
        .done_rdata (done_rdata)
    );

    axil_resp_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_resp (
        .seq        (seq),
        .rst        (rst),
        .done       (done),
        .done_write (done_write),
        .done_resp  (done_resp),
        .done_rdata (done_rdata),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .rresp      (rresp),
        .rdata      (rdata),
        .b_full     (b_full),
        .r_full     (r_full)
    );

endmodule

/* axil_req_arbiter.sv */
`timescale 1ns/100ps

module axil_req_arbiter #(
    parameter int ADDR_WIDTH = apb_bridge_pkg::DEFAULT_ADDR_WIDTH,
    parameter int DATA_WIDTH = apb_bridge_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                                  seq,
    input  logic                                  rst,

    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [ADDR_WIDTH-1:0]                 awaddr,
    input  logic [apb_bridge_pkg::PROT_WIDTH-1:0] awprot,

    input  logic                                  wvalid,
    output logic                                  wready,
    input  logic [DATA_WIDTH-1:0]                 wdata,
    input  logic [DATA_WIDTH/8-1:0]               wstrb,

    input  logic                                  arvalid,
    output logic                                  arready,
    input  logic [ADDR_WIDTH-1:0]                 araddr,
    input  logic [apb_bridge_pkg::PROT_WIDTH-1:0] arprot,

    input  logic                                  busy,
    input  logic                                  b_full,
    input  logic                                  r_full,

    output logic                                  req,
    output logic                                  req_write,
    output logic [ADDR_WIDTH-1:0]                 req_addr,
    output logic [apb_bridge_pkg::PROT_WIDTH-1:0] req_prot,
    output logic [DATA_WIDTH-1:0]                 req_wdata,
    output logic [DATA_WIDTH/8-1:0]               req_strb
);

    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    logic last_write;
    logic idle;
    logic want_w;
    logic want_r;
    logic take_w;
    logic take_r;

    // req covers the one cycle before the FSM reports busy
    assign idle   = !busy && !req;
    assign want_w = awvalid && wvalid && !b_full; // AW and W go together
    assign want_r = arvalid && !r_full;

    always_comb begin
        take_w = 1'b0;
        take_r = 1'b0;
        if (idle) begin
            if (want_w && want_r) begin
                take_r = last_write;  // the side not served last time wins
                take_w = !last_write;
            end else begin
                take_w = want_w;
                take_r = want_r;
            end
        end
    end

    assign awready = take_w;
    assign wready  = take_w;
    assign arready = take_r;

    always_ff @(posedge seq) begin
        if (rst) begin
            req        <= 1'b0;
            last_write <= 1'b0; // a write goes first after reset
        end else begin
            req <= take_w || take_r;
            if (take_w || take_r) begin
                last_write <= take_w;
            end
        end
    end

    always_ff @(posedge seq) begin
        if (take_w) begin
            req_write <= 1'b1;
            req_addr  <= awaddr;
            req_prot  <= awprot;
            req_wdata <= wdata;
            req_strb  <= wstrb;
        end else if (take_r) begin
            req_write <= 1'b0;
            req_addr  <= araddr;
            req_prot  <= arprot;
            req_wdata <= '0;
            req_strb  <= {STRB_WIDTH{1'b0}}; // APB wants pstrb low on reads
        end
    end

endmodule

/* axil_resp_unit.sv */
`timescale 1ns/100ps

module axil_resp_unit #(
    parameter int DATA_WIDTH = apb_bridge_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                  seq,
    input  logic                  rst,

    input  logic                  done,
    input  logic                  done_write,
    input  apb_bridge_pkg::resp_t done_resp,
    input  logic [DATA_WIDTH-1:0] done_rdata,

    output logic                  bvalid,
    input  logic                  bready,
    output apb_bridge_pkg::resp_t bresp,

    output logic                  rvalid,
    input  logic                  rready,
    output apb_bridge_pkg::resp_t rresp,
    output logic [DATA_WIDTH-1:0] rdata,

    output logic                  b_full,
    output logic                  r_full
);

    logic load_b;
    logic load_r;

    assign load_b = done && done_write;
    assign load_r = done && !done_write;

    always_ff @(posedge seq) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (load_b) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (load_r) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge seq) begin
        if (load_b) begin
            bresp <= done_resp;
        end
        if (load_r) begin
            rresp <= done_resp;
            rdata <= done_rdata;
        end
    end

    // the arbiter only starts a transfer whose slot is empty
    assign b_full = bvalid;
    assign r_full = rvalid;

endmodule

/* build.f */
apb_bridge_pkg.sv
axil_req_arbiter.sv
apb_master_fsm.sv
axil_resp_unit.sv
axil_apb_bridge.sv
tb_axil_apb_bridge.sv

/* tb_axil_apb_bridge.sv */
`timescale 1ns/100ps

module tb_axil_apb_bridge;

    localparam int NO_APBS   = 8;
    localparam int SPAN_BITS = 16;
    localparam int ERR_SLAVE = 5;
    localparam int TIMEOUT   = 50; // cycles allowed for any single wait

    localparam logic [apb_bridge_pkg::PROT_WIDTH-1:0] WR_PROT = 3'b010;
    localparam logic [apb_bridge_pkg::PROT_WIDTH-1:0] RD_PROT = 3'b001;

    logic seq;
    logic rst;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] awaddr, wdata, araddr, rdata, paddr, pwdata;
    logic [3:0] wstrb, pstrb;
    logic [apb_bridge_pkg::PROT_WIDTH-1:0] awprot, arprot, pprot;
    apb_bridge_pkg::resp_t bresp, rresp;
    logic pwrite;
    logic psel [NO_APBS];
    logic penable [NO_APBS];
    logic pready [NO_APBS] = '{default: 1'b0};
    logic [31:0] prdata [NO_APBS] = '{default: 32'h0};
    logic pslverr [NO_APBS] = '{default: 1'b0};

    logic [NO_APBS-1:0] psel_v, penable_v, pready_v;
    logic xfer_end;
    logic no_apb = 1'b0; // set while a transaction must not reach any slave
    logic [31:0] mem [NO_APBS][256];
    int wait_cnt [NO_APBS];
    logic [47:0] xfer_log [$]; // {pprot, pstrb, pwrite, slave, paddr} of every finished transfer
    integer seed = 32'h66ba4d7b;
    int errors = 0;
    int checks = 0;

    axil_apb_bridge #(
        .NO_APBS         (NO_APBS),
        .ADDR_WIDTH      (32),
        .DATA_WIDTH      (32),
        .SLAVE_SPAN_BITS (SPAN_BITS)
    ) UUT (.*);

    initial begin
        seq = 1'b0;
        forever #50 seq = ~seq;
    end

    always_comb begin
        for (int i = 0; i < NO_APBS; i++) begin
            psel_v[i]    = psel[i];
            penable_v[i] = penable[i];
            pready_v[i]  = pready[i];
        end
    end

    assign xfer_end = |(psel_v & penable_v & pready_v);

    // each slave answers after 0 to 3 wait states and keeps a small word memory
    always @(posedge seq) begin
        for (int i = 0; i < NO_APBS; i++) begin
            if (psel[i] && !penable[i]) begin
                wait_cnt[i] = $unsigned($random(seed)) % 4;
                pready[i]  <= (wait_cnt[i] == 0);
                pslverr[i] <= (i == ERR_SLAVE) && (paddr[7:0] == 8'hee);
                prdata[i]  <= mem[i][paddr[9:2]];
            end else if (psel[i] && penable[i]) begin
                if (pready[i]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (pwrite && pstrb[b]) begin
                            mem[i][paddr[9:2]][8*b +: 8] = pwdata[8*b +: 8];
                        end
                    end
                    xfer_log.push_back({pprot, pstrb, pwrite, 8'(i), paddr});
                    pready[i]  <= 1'b0;
                    pslverr[i] <= 1'b0;
                end else begin
                    wait_cnt[i] = wait_cnt[i] - 1;
                    pready[i] <= (wait_cnt[i] == 0);
                end
            end
        end
    end

    a_one_psel: assert property (@(posedge seq) disable iff (rst) $onehot0(psel_v))
        else report_protocol("more than one psel is high");
    a_enable_sel: assert property (@(posedge seq) disable iff (rst) (penable_v & ~psel_v) == '0)
        else report_protocol("penable is high without its psel");
    a_setup_access: assert property (@(posedge seq) disable iff (rst)
        (|psel_v && penable_v == '0) |=> penable_v == $past(psel_v))
        else report_protocol("setup phase was not followed by access on the same slave");
    a_access_setup: assert property (@(posedge seq) disable iff (rst)
        $rose(|penable_v) |-> $past(|psel_v))
        else report_protocol("penable rose without a setup cycle before it");
    a_stable: assert property (@(posedge seq) disable iff (rst)
        (|psel_v && !xfer_end) |=> (|psel_v && $stable(paddr) && $stable(pwrite)
                                    && $stable(pwdata)))
        else report_protocol("paddr, pwrite or pwdata changed during a transfer");
    a_end: assert property (@(posedge seq) disable iff (rst)
        xfer_end |=> (psel_v == '0 && penable_v == '0))
        else report_protocol("psel or penable stayed high after the pready edge");
    a_no_apb: assert property (@(posedge seq) disable iff (rst) no_apb |-> psel_v == '0)
        else report_protocol("a decode error transaction selected an APB slave");
    a_b_hold: assert property (@(posedge seq) disable iff (rst)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
        else report_protocol("bvalid or bresp changed while bready was low");

    task automatic report_protocol(input string what);
        errors++;
        $display("%0t: protocol violation, %s", $time, what);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_xfer(input int idx, input logic wr, input int slv, input logic [31:0] a);
        logic [apb_bridge_pkg::PROT_WIDTH-1:0] prot;
        logic [3:0] strb;
        prot = wr ? WR_PROT : RD_PROT;
        strb = wr ? 4'hf : 4'h0; // APB keeps pstrb low on reads
        check_value("apb transfer {pprot,pstrb,pwrite,slave,paddr}",
                    {prot, strb, wr, 8'(slv), a}, xfer_log[idx]);
    endtask

    task automatic timeout_fail(input string what);
        $display("%0t: timeout while waiting for %s", $time, what);
        $display("checks %0d, errors %0d", checks, errors);
        $display("** FAIL **");
        $finish;
    endtask

    function automatic logic [31:0] window_addr(input int slv, input logic [31:0] offset);
        return (32'(slv) << SPAN_BITS) | offset;
    endfunction

    task automatic send_write(input logic [31:0] a, input logic [31:0] d);
        int t;
        logic ok;
        awvalid <= 1'b1;
        awaddr  <= a;
        awprot  <= WR_PROT;
        wvalid  <= 1'b1;
        wdata   <= d;
        wstrb   <= 4'hf;
        t = 0;
        do begin
            @(posedge seq);
            t++;
            ok = awready && wready;
        end while (!ok && t < TIMEOUT);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (!ok) timeout_fail("the AW and W handshake");
    endtask

    task automatic take_b(output apb_bridge_pkg::resp_t resp);
        int t;
        logic ok;
        t = 0;
        do begin
            @(posedge seq);
            t++;
            ok = bvalid && bready;
            resp = bresp;
        end while (!ok && t < TIMEOUT);
        if (!ok) timeout_fail("the write response");
    endtask

    task automatic wait_bvalid();
        int t;
        t = 0;
        while (!bvalid && t < TIMEOUT) begin
            @(posedge seq);
            t++;
        end
        if (!bvalid) timeout_fail("bvalid");
    endtask

    task automatic send_read(input logic [31:0] a);
        int t;
        logic ok;
        arvalid <= 1'b1;
        araddr  <= a;
        arprot  <= RD_PROT;
        t = 0;
        do begin
            @(posedge seq);
            t++;
            ok = arready;
        end while (!ok && t < TIMEOUT);
        arvalid <= 1'b0;
        if (!ok) timeout_fail("the AR handshake");
    endtask

    task automatic take_r(output logic [31:0] d, output apb_bridge_pkg::resp_t resp);
        int t;
        logic ok;
        t = 0;
        do begin
            @(posedge seq);
            t++;
            ok = rvalid && rready;
            d = rdata;
            resp = rresp;
        end while (!ok && t < TIMEOUT);
        if (!ok) timeout_fail("the read response");
    endtask

    task automatic axi_write(input logic [31:0] a, input logic [31:0] d,
                             output apb_bridge_pkg::resp_t resp);
        send_write(a, d);
        take_b(resp);
    endtask

    task automatic axi_read(input logic [31:0] a, output logic [31:0] d,
                            output apb_bridge_pkg::resp_t resp);
        send_read(a);
        take_r(d, resp);
    endtask

    initial begin
        logic [31:0] addr, data, rd;
        apb_bridge_pkg::resp_t resp, resp2;
        int nlog;
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        awprot  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b1;
        arvalid = 1'b0;
        araddr  = '0;
        arprot  = '0;
        rready  = 1'b1;
        repeat (5) @(posedge seq);
        rst <= 1'b0;

        for (int i = 0; i < NO_APBS; i++) begin
            addr = window_addr(i, 32'h40 + 4 * i);
            data = addr ^ 32'h5a5a_1234;
            axi_write(addr, data, resp);
            check_value("bresp", apb_bridge_pkg::RESP_OKAY, resp);
            check_xfer(xfer_log.size() - 1, 1'b1, i, addr);
            axi_read(addr, rd, resp);
            check_value("rresp", apb_bridge_pkg::RESP_OKAY, resp);
            check_value("rdata", data, rd);
            check_xfer(xfer_log.size() - 1, 1'b0, i, addr);
        end

        // addresses past the last window
        nlog = xfer_log.size();
        no_apb <= 1'b1;
        axi_write(window_addr(NO_APBS, 32'h10), 32'h1234_5678, resp);
        check_value("bresp", apb_bridge_pkg::RESP_DECERR, resp);
        axi_read(32'hffff_fff0, rd, resp);
        check_value("rresp", apb_bridge_pkg::RESP_DECERR, resp);
        no_apb <= 1'b0;
        check_value("apb transfer count", nlog, xfer_log.size());

        axi_write(window_addr(ERR_SLAVE, 32'h1ee), 32'hdead_beef, resp);
        check_value("bresp", apb_bridge_pkg::RESP_SLVERR, resp);
        axi_read(window_addr(ERR_SLAVE, 32'h2ee), rd, resp);
        check_value("rresp", apb_bridge_pkg::RESP_SLVERR, resp);

        // a read was served last, so the write must win the tie
        addr = window_addr(2, 32'h80);
        fork
            axi_write(addr, 32'hfeed_0002, resp);
            axi_read(addr, rd, resp2);
        join
        check_value("bresp", apb_bridge_pkg::RESP_OKAY, resp);
        check_value("rresp", apb_bridge_pkg::RESP_OKAY, resp2);
        check_value("rdata", 32'hfeed_0002, rd);
        check_xfer(xfer_log.size() - 2, 1'b1, 2, addr);
        check_xfer(xfer_log.size() - 1, 1'b0, 2, addr);

        bready <= 1'b0;
        send_write(window_addr(6, 32'h20), 32'h0600_0020);
        wait_bvalid();
        check_value("bresp", apb_bridge_pkg::RESP_OKAY, bresp);
        nlog = xfer_log.size();
        fork
            send_write(window_addr(6, 32'h24), 32'h0600_0024);
            begin
                axi_read(addr, rd, resp2);
                check_value("rresp", apb_bridge_pkg::RESP_OKAY, resp2);
                check_value("rdata", 32'hfeed_0002, rd);
                repeat (10) @(posedge seq); // a write that ignored the full slot would be on APB by now
                check_value("apb transfer count", nlog + 1, xfer_log.size());
                check_value("bvalid", 1'b1, bvalid);
                bready <= 1'b1;
            end
        join
        take_b(resp);
        check_value("bresp", apb_bridge_pkg::RESP_OKAY, resp);
        check_xfer(xfer_log.size() - 1, 1'b1, 6, window_addr(6, 32'h24));

        // a write was served last, so the read goes first and still sees the old word
        addr = window_addr(3, 32'h4c);
        fork
            axi_write(addr, 32'hfeed_0003, resp);
            axi_read(addr, rd, resp2);
        join
        check_value("bresp", apb_bridge_pkg::RESP_OKAY, resp);
        check_value("rresp", apb_bridge_pkg::RESP_OKAY, resp2);
        check_value("rdata", addr ^ 32'h5a5a_1234, rd);
        check_xfer(xfer_log.size() - 2, 1'b0, 3, addr);
        check_xfer(xfer_log.size() - 1, 1'b1, 3, addr);

        repeat (5) @(posedge seq);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
